/* logic/afu_config.svh */
/* Fixed layout and identifiers of the AFU register space. Both regions must be
   aligned to REGION_BYTES, and REGION_BYTES must hold exactly 1024 64-bit words */
`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// ==================================================
// Host address space
// ==================================================

// Width of the host byte address on the Wishbone port
`define MMIO_ADDR_BITS 18

// Byte address of the feature block that follows the AFU header
`define FEATURE_BASE 'h2000

// Size of each register region in bytes (1024 words of 8 bytes)
`define REGION_BYTES 'h2000

// ==================================================
// Identifiers
// ==================================================

// Lower and upper halves of the 128-bit AFU identifier
`define AFU_ID_LO 64'h9f3c_52e1_b07a_4d68
`define AFU_ID_HI 64'h6e41_0c8b_a2d7_35f9

// 12-bit identifier reported in the feature block header
`define FEATURE_ID 12'h0a5

`endif

/* logic/mmioPkg.sv */
/* Types of the host bus side. The address width comes from the shared config
   header, so that header must be on the include path when this package compiles */
`include "afu_config.svh"

package mmioPkg;

  // Byte address as the host presents it on wbAdr
  typedef logic [`MMIO_ADDR_BITS-1:0] mmioAddr_t;

  // Word offset inside one region
  // 1024 words of 8 bytes cover one full region
  typedef logic [9:0] regOffset_t;

  // Region that a host address falls into
  // NONE covers every address outside both register blocks
  typedef enum logic [1:0]
  {
    AFU     = 2'd0,
    FEATURE = 2'd1,
    NONE    = 2'd2
  } region_t;

endpackage

/* logic/dfhPkg.sv */
/* Device feature header layout and register word types. Only feature types
   AFU and PRIVATE are defined, since no other kind exists in this chain */
package dfhPkg;

  // One register word as seen on the host bus
  typedef logic [63:0] csrData_t;

  // Feature type codes in bits 63:60 of a header
  typedef enum logic [3:0]
  {
    AFU     = 4'h1,
    PRIVATE = 4'h3
  } featureType_t;

  // Header fields from the most significant bit down
  // The sizes add up to exactly one 64-bit word
  typedef struct packed
  {
    featureType_t featureType;
    logic [18:0]  reserved;
    // Set only in the last header of the chain
    logic         endOfList;
    // Byte distance from this header to the next one
    logic [23:0]  nextOffset;
    logic [3:0]   revision;
    logic [11:0]  featureId;
  } dfhFields_t;

  // The register blocks build a header by fields
  // The bus carries the same word as raw data
  typedef union packed
  {
    dfhFields_t fields;
    csrData_t   raw;
  } dfhWord_t;

endpackage

/* logic/mmioIf.sv */
/* One decoded register access from the decoder to a register block.
   Carries no clock; both ends sample it on the shared pClk */
`timescale 1ns/1ns

interface mmioIf;

  // One-cycle pulse in the cycle the host request is accepted
  logic sel;

  // High for a write, low for a read
  logic we;

  // Word offset inside the selected region
  mmioPkg::regOffset_t offset;

  // Write data, valid while sel and we are high
  dfhPkg::csrData_t wdata;

  // Read data, combinational from offset
  dfhPkg::csrData_t rdata;

  // Decoder side drives the access and takes back the read word
  modport decoder (output sel, output we, output offset, output wdata, input rdata);

  // Register block side
  modport target (input sel, input we, input offset, input wdata, output rdata);

endinterface

/* logic/afuCsr.sv */
/* AFU register block at the start of the chain. Offsets outside the word map
   read zero and writes to any word other than scratch are dropped */
`timescale 1ns/1ns
`include "afu_config.svh"

module afuCsr
(
  input  logic          pClk,
  input  logic          rstN,
  mmioIf.target         bus
);

  // ==================================================
  // Word map
  // ==================================================

  // Header of the AFU feature
  localparam mmioPkg::regOffset_t headerWord = mmioPkg::regOffset_t'(0);

  // Lower half of the AFU identifier
  localparam mmioPkg::regOffset_t idLoWord = mmioPkg::regOffset_t'(1);

  // Upper half of the AFU identifier
  localparam mmioPkg::regOffset_t idHiWord = mmioPkg::regOffset_t'(2);

  // Pointer to a next AFU, always zero here
  localparam mmioPkg::regOffset_t nextAfuWord = mmioPkg::regOffset_t'(3);

  // Host scratch register
  localparam mmioPkg::regOffset_t scratchWord = mmioPkg::regOffset_t'(4);

  dfhPkg::dfhWord_t header;
  dfhPkg::csrData_t scratch;

  // ==================================================
  // AFU header
  // ==================================================

  // The header points to the feature block, which continues the chain
  always_comb
  begin
    header.fields.featureType = dfhPkg::AFU;
    header.fields.reserved    = '0;
    header.fields.endOfList   = 1'b0;
    header.fields.nextOffset  = 24'(`FEATURE_BASE);
    header.fields.revision    = 4'h0;
    header.fields.featureId   = 12'h000;
  end

  // ==================================================
  // Scratch register
  // ==================================================

  // The write lands on the edge that ends the acceptance cycle
  always_ff @(posedge pClk)
  begin
    if (!rstN)
    begin
      scratch <= '0;
    end
    else if (bus.sel && bus.we && (bus.offset == scratchWord))
    begin
      scratch <= bus.wdata;
    end
  end

  // Read data follows the offset in the same cycle
  // The decoder registers it into the host response
  always_comb
  begin
    case (bus.offset)
      headerWord:  bus.rdata = header.raw;
      idLoWord:    bus.rdata = `AFU_ID_LO;
      idHiWord:    bus.rdata = `AFU_ID_HI;
      // No other AFU follows this one
      nextAfuWord: bus.rdata = '0;
      scratchWord: bus.rdata = scratch;
      default:     bus.rdata = '0;
    endcase
  end

endmodule

/* logic/featureCsr.sv */
/* Private feature block that ends the chain. The write counter counts every
   write to this region, also those that hit read-only or unmapped words */
`timescale 1ns/1ns
`include "afu_config.svh"

module featureCsr
(
  input  logic          pClk,
  input  logic          rstN,
  mmioIf.target         bus
);

  // ==================================================
  // Word map
  // ==================================================

  localparam mmioPkg::regOffset_t headerWord  = mmioPkg::regOffset_t'(0);
  localparam mmioPkg::regOffset_t controlWord = mmioPkg::regOffset_t'(1);
  localparam mmioPkg::regOffset_t countWord   = mmioPkg::regOffset_t'(2);

  dfhPkg::dfhWord_t header;
  dfhPkg::csrData_t control;
  dfhPkg::csrData_t writeCount;

  // Last header of the chain, so the next offset stays zero
  always_comb
  begin
    header.fields.featureType = dfhPkg::PRIVATE;
    header.fields.reserved    = '0;
    header.fields.endOfList   = 1'b1;
    header.fields.nextOffset  = '0;
    header.fields.revision    = 4'h0;
    header.fields.featureId   = `FEATURE_ID;
  end

  // ==================================================
  // Control register and write counter
  // ==================================================

  always_ff @(posedge pClk)
  begin
    if (!rstN)
    begin
      control    <= '0;
      writeCount <= '0;
    end
    else if (bus.sel && bus.we)
    begin
      // Any write to this region is counted whatever its offset
      writeCount <= writeCount + 64'd1;
      if (bus.offset == controlWord)
      begin
        control <= bus.wdata;
      end
    end
  end

  // Unmapped offsets read zero
  always_comb
  begin
    case (bus.offset)
      headerWord:  bus.rdata = header.raw;
      controlWord: bus.rdata = control;
      countWord:   bus.rdata = writeCount;
      default:     bus.rdata = '0;
    endcase
  end

endmodule

/* logic/mmioDecode.sv */
/* Wishbone classic slave for full 64-bit word accesses only. Byte selects,
   err and retry do not exist; the low three address bits are ignored */
`timescale 1ns/1ns
`include "afu_config.svh"

module mmioDecode
(
  input  logic                 pClk,
  input  logic                 rstN,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,
  input  mmioPkg::mmioAddr_t   wbAdr,
  input  dfhPkg::csrData_t     wbDatW,
  output dfhPkg::csrData_t     wbDatR,
  output logic                 wbAck,
  mmioIf.decoder               afuPort,
  mmioIf.decoder               featurePort
);

  // Byte address bits below the 64-bit word
  localparam int wordShift = 3;

  // Region bounds as host byte addresses
  localparam mmioPkg::mmioAddr_t regionBytes = mmioPkg::mmioAddr_t'(`REGION_BYTES);
  localparam mmioPkg::mmioAddr_t featureBase = mmioPkg::mmioAddr_t'(`FEATURE_BASE);
  localparam mmioPkg::mmioAddr_t featureEnd  = featureBase + regionBytes;

  logic                accept;
  mmioPkg::region_t    region;
  mmioPkg::regOffset_t offset;

  // ==================================================
  // Address decode
  // ==================================================

  // The AFU region starts at address zero
  always_comb
  begin
    if (wbAdr < regionBytes)
    begin
      region = mmioPkg::AFU;
    end
    else if ((wbAdr >= featureBase) && (wbAdr < featureEnd))
    begin
      region = mmioPkg::FEATURE;
    end
    else
    begin
      region = mmioPkg::NONE;
    end
  end

  // Regions are aligned to their size, so dropping the upper bits of the
  // word address leaves the offset inside the region
  assign offset = mmioPkg::regOffset_t'(wbAdr >> wordShift);

  // A pending request is taken in the first cycle that has no acknowledge
  // This also keeps wbAck low for a cycle between two accesses
  assign accept = wbCyc && wbStb && !wbAck;

  // ==================================================
  // Access routing
  // ==================================================

  assign afuPort.sel    = accept && (region == mmioPkg::AFU);
  assign afuPort.we     = wbWe;
  assign afuPort.offset = offset;
  assign afuPort.wdata  = wbDatW;

  assign featurePort.sel    = accept && (region == mmioPkg::FEATURE);
  assign featurePort.we     = wbWe;
  assign featurePort.offset = offset;
  assign featurePort.wdata  = wbDatW;

  // ==================================================
  // Response
  // ==================================================

  // Unmapped addresses answer all ones and still get an acknowledge
  always_ff @(posedge pClk)
  begin
    if (accept)
    begin
      case (region)
        mmioPkg::AFU:     wbDatR <= afuPort.rdata;
        mmioPkg::FEATURE: wbDatR <= featurePort.rdata;
        default:          wbDatR <= '1;
      endcase
    end
  end

  // Acknowledge is high for exactly the cycle after acceptance
  always_ff @(posedge pClk)
  begin
    if (!rstN)
    begin
      wbAck <= 1'b0;
    end
    else
    begin
      wbAck <= accept;
    end
  end

endmodule

/* logic/ccipStdAfu.sv */
/* Top level of the AFU shell with a single clock and plain Wishbone host ports.
   The register space holds only the AFU header and one private feature */
`timescale 1ns/1ns

module ccipStdAfu
(
  // Primary interface clock
  input  logic                 pClk,

  // Synchronous reset, active low
  input  logic                 rstN,

  // ==================================================
  // Wishbone classic slave port
  // ==================================================

  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,

  // Byte address of a full 64-bit word
  input  mmioPkg::mmioAddr_t   wbAdr,

  input  dfhPkg::csrData_t     wbDatW,

  // Valid in the cycle that wbAck is high
  output dfhPkg::csrData_t     wbDatR,

  output logic                 wbAck
);

  // Decoded access toward the AFU register block
  mmioIf afuBus();

  // Decoded access toward the feature register block
  mmioIf featureBus();

  // ==================================================
  // Host decoder
  // ==================================================

  mmioDecode decode
  (
    .pClk        (pClk),
    .rstN        (rstN),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatW      (wbDatW),
    .wbDatR      (wbDatR),
    .wbAck       (wbAck),
    .afuPort     (afuBus.decoder),
    .featurePort (featureBus.decoder)
  );

  // ==================================================
  // Register blocks
  // ==================================================

  // First header of the chain at address zero
  afuCsr afuRegs
  (
    .pClk (pClk),
    .rstN (rstN),
    .bus  (afuBus.target)
  );

  // Feature block that ends the chain
  featureCsr featureRegs
  (
    .pClk (pClk),
    .rstN (rstN),
    .bus  (featureBus.target)
  );

endmodule

/* tests/ccipStdAfu_asserts.sv */
/* Wishbone handshake rules at the AFU top level. Assumes one outstanding
   access at a time; failCount is read by the testbench */
`timescale 1ns/1ns

module ccipStdAfuAsserts
(
  input logic pClk,
  input logic rstN,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck
);

  // Number of rule violations seen so far
  int failCount = 0;

  // A request that the slave takes in this cycle
  logic accept;

  assign accept = wbCyc && wbStb && !wbAck;

  // ==================================================
  // Handshake rules
  // ==================================================

  // Sampled on the falling edge, before the host reacts to the acknowledge
  ackNeedsRequest: assert property (@(negedge pClk) disable iff (!rstN)
    wbAck |-> (wbCyc && wbStb))
  else
  begin
    failCount++;
    $error("wbAck high without wbCyc and wbStb");
  end

  ackOneCycle: assert property (@(posedge pClk) disable iff (!rstN)
    wbAck |=> !wbAck)
  else
  begin
    failCount++;
    $error("wbAck stayed high for more than one cycle");
  end

  // Every accepted request is acknowledged in the very next cycle
  ackAfterAccept: assert property (@(posedge pClk) disable iff (!rstN)
    accept |=> wbAck)
  else
  begin
    failCount++;
    $error("Accepted request not acknowledged one cycle later");
  end

  // And no acknowledge appears without an acceptance just before it
  ackHasAccept: assert property (@(posedge pClk) disable iff (!rstN)
    wbAck |-> $past(accept))
  else
  begin
    failCount++;
    $error("wbAck high without an accepted request in the cycle before");
  end

  ackLowInReset: assert property (@(posedge pClk)
    !rstN |=> !wbAck)
  else
  begin
    failCount++;
    $error("wbAck high while rstN is low");
  end

endmodule

bind ccipStdAfu ccipStdAfuAsserts handshakeChecks
(
  .pClk  (pClk),
  .rstN  (rstN),
  .wbCyc (wbCyc),
  .wbStb (wbStb),
  .wbAck (wbAck)
);

/* tests/ccipStdAfuTb.sv */
/* Self-checking testbench of the AFU shell. Only aligned 64-bit accesses,
   one outstanding at a time; a new task call starts on a falling edge */
`timescale 1ns/1ns
`include "afu_config.svh"

module ccipStdAfuTb;

  // Longest waits, in clock cycles
  localparam int ackTimeout   = 20;
  localparam int drainTimeout = 50;

  // Byte addresses from the word maps of both regions
  localparam mmioPkg::mmioAddr_t idLoAdr    = 'h08;
  localparam mmioPkg::mmioAddr_t idHiAdr    = 'h10;
  localparam mmioPkg::mmioAddr_t nextAfuAdr = 'h18;
  localparam mmioPkg::mmioAddr_t scratchAdr = 'h20;
  localparam mmioPkg::mmioAddr_t featureAdr = `FEATURE_BASE;
  localparam mmioPkg::mmioAddr_t controlAdr = `FEATURE_BASE + 'h08;
  localparam mmioPkg::mmioAddr_t countAdr   = `FEATURE_BASE + 'h10;

  logic               pClk;
  logic               rstN;
  logic               wbCyc;
  logic               wbStb;
  logic               wbWe;
  mmioPkg::mmioAddr_t wbAdr;
  dfhPkg::csrData_t   wbDatW;
  dfhPkg::csrData_t   wbDatR;
  logic               wbAck;

  // Accesses on the bus waiting for their acknowledge, oldest first
  mmioPkg::mmioAddr_t pendAdr[$];
  bit                 pendWe[$];
  dfhPkg::csrData_t   pendData[$];

  // Model of the host-writable state
  dfhPkg::csrData_t scratchModel = '0;
  dfhPkg::csrData_t controlModel = '0;
  dfhPkg::csrData_t countModel   = '0;

  ccipStdAfu uut
  (
    .pClk   (pClk),
    .rstN   (rstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  always #2 pClk = ~pClk;

  // ==================================================
  // Reference model and compare tasks
  // ==================================================

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Expected read word from the address map and the modeled state
  function automatic dfhPkg::csrData_t refWord(input mmioPkg::mmioAddr_t adr,
    input dfhPkg::csrData_t scratch, input dfhPkg::csrData_t control,
    input dfhPkg::csrData_t count);
    dfhPkg::dfhWord_t head;
    dfhPkg::csrData_t result;
    int unsigned      word;
    head.raw = '0;
    result   = '1;
    if (adr < `REGION_BYTES)
    begin
      word = adr / 8;
      head.fields.featureType = dfhPkg::AFU;
      head.fields.nextOffset  = `FEATURE_BASE;
      case (word)
        0:       result = head.raw;
        1:       result = `AFU_ID_LO;
        2:       result = `AFU_ID_HI;
        4:       result = scratch;
        default: result = '0;
      endcase
    end
    else if ((adr >= `FEATURE_BASE) && (adr < `FEATURE_BASE + `REGION_BYTES))
    begin
      word = (adr - `FEATURE_BASE) / 8;
      head.fields.featureType = dfhPkg::PRIVATE;
      head.fields.endOfList   = 1'b1;
      head.fields.featureId   = `FEATURE_ID;
      case (word)
        0:       result = head.raw;
        1:       result = control;
        2:       result = count;
        default: result = '0;
      endcase
    end
    return result;
  endfunction

  function automatic bit isHeader(input mmioPkg::mmioAddr_t adr);
    return (adr == 0) || (adr == `FEATURE_BASE);
  endfunction

  // Model update for a write that was acknowledged
  task automatic applyWrite(input mmioPkg::mmioAddr_t adr, input dfhPkg::csrData_t data);
    if ((adr < `REGION_BYTES) && ((adr / 8) == 4))
    begin
      scratchModel = data;
    end
    else if ((adr >= `FEATURE_BASE) && (adr < `FEATURE_BASE + `REGION_BYTES))
    begin
      // Every write to the feature region counts, whatever its offset
      countModel = countModel + 1;
      if (((adr - `FEATURE_BASE) / 8) == 1)
      begin
        controlModel = data;
      end
    end
  endtask

  task automatic checkCsr(input string name, input dfhPkg::csrData_t got,
    input dfhPkg::csrData_t expected);
    if (got !== expected)
      failRun($sformatf("[ERROR] %s got %h expected %h", name, got, expected));
  endtask

  // Field by field, so a bad header names the field that differs
  task automatic checkDfh(input string name, input dfhPkg::dfhWord_t got,
    input dfhPkg::dfhWord_t expected);
    if (got.fields.featureType !== expected.fields.featureType)
      failRun($sformatf("[ERROR] %s.featureType got %h expected %h", name,
        got.fields.featureType, expected.fields.featureType));
    if (got.fields.endOfList !== expected.fields.endOfList)
      failRun($sformatf("[ERROR] %s.endOfList got %h expected %h", name,
        got.fields.endOfList, expected.fields.endOfList));
    if (got.fields.nextOffset !== expected.fields.nextOffset)
      failRun($sformatf("[ERROR] %s.nextOffset got %h expected %h", name,
        got.fields.nextOffset, expected.fields.nextOffset));
    if (got.fields.featureId !== expected.fields.featureId)
      failRun($sformatf("[ERROR] %s.featureId got %h expected %h", name,
        got.fields.featureId, expected.fields.featureId));
    // Reserved and revision are covered by the whole word
    checkCsr(name, got.raw, expected.raw);
  endtask

  // Every acknowledge retires the oldest access; reads are checked here
  always @(negedge pClk)
  begin : compare
    mmioPkg::mmioAddr_t adr;
    dfhPkg::csrData_t   data;
    dfhPkg::csrData_t   expected;
    bit                 we;
    string              name;
    if (rstN && (wbAck === 1'b1))
    begin
      if (pendAdr.size() == 0)
        failRun("Acknowledge seen with no request outstanding");
      adr  = pendAdr.pop_front();
      we   = pendWe.pop_front();
      data = pendData.pop_front();
      if (we)
      begin
        applyWrite(adr, data);
      end
      else
      begin
        expected = refWord(adr, scratchModel, controlModel, countModel);
        name     = $sformatf("wbDatR (address %h)", adr);
        if (isHeader(adr))
          checkDfh(name, wbDatR, expected);
        else
          checkCsr(name, wbDatR, expected);
      end
    end
    if (uut.handshakeChecks.failCount != 0)
      failRun("A Wishbone handshake assertion failed");
  end

  // ==================================================
  // Bus tasks
  // ==================================================

  task automatic waitAck();
    int waited;
    waited = 0;
    do
    begin
      @(negedge pClk);
      waited++;
      if (waited > ackTimeout)
        failRun("Timeout while waiting for wbAck after a request");
    end
    while (wbAck !== 1'b1);
  endtask

  // With keepStb the request lines stay high so the next call follows at once
  task automatic startAccess(input bit we, input mmioPkg::mmioAddr_t adr,
    input dfhPkg::csrData_t data);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = data;
    pendAdr.push_back(adr);
    pendWe.push_back(we);
    pendData.push_back(data);
  endtask

  task automatic endAccess(input bit keepStb);
    if (!keepStb)
    begin
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
    end
  endtask

  task automatic wbWrite(input mmioPkg::mmioAddr_t adr, input dfhPkg::csrData_t data,
    input bit keepStb);
    startAccess(1'b1, adr, data);
    waitAck();
    endAccess(keepStb);
  endtask

  task automatic wbRead(input mmioPkg::mmioAddr_t adr, input bit keepStb,
    output dfhPkg::csrData_t data);
    startAccess(1'b0, adr, '0);
    waitAck();
    data = wbDatR;
    endAccess(keepStb);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge pClk);
  endtask

  function automatic dfhPkg::csrData_t randomWord();
    return {$urandom(), $urandom()};
  endfunction

  // Mapped, unmapped and out-of-range words for the mixed traffic
  function automatic mmioPkg::mmioAddr_t randomAddr();
    case ($urandom_range(0, 7))
      0:       return 'h0;
      1:       return scratchAdr;
      2:       return idHiAdr;
      3:       return featureAdr;
      4:       return controlAdr;
      5:       return countAdr;
      6:       return `FEATURE_BASE + 'h1f8;
      default: return 'h4000 + ($urandom_range(0, 'h7ff) * 8);
    endcase
  endfunction

  // ==================================================
  // Sequences
  // ==================================================

  initial
  begin : stimulus
    dfhPkg::csrData_t   word;
    dfhPkg::dfhWord_t   head;
    mmioPkg::mmioAddr_t next;
    mmioPkg::mmioAddr_t adr;
    bit                 hold;
    int                 waited;
    void'($urandom(32'hd1ec));
    pClk   = 1'b0;
    rstN   = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    repeat (16) @(negedge pClk);
    rstN = 1'b1;

    // Walk the feature chain from address zero
    wbRead('h0, 1'b0, word);
    head = word;
    checkCsr("AFU header endOfList", 64'(head.fields.endOfList), 64'd0);
    checkCsr("AFU header nextOffset", 64'(head.fields.nextOffset), 64'(`FEATURE_BASE));
    next = mmioPkg::mmioAddr_t'(head.fields.nextOffset);
    wbRead(next, 1'b0, word);
    head = word;
    checkCsr("Feature header endOfList", 64'(head.fields.endOfList), 64'd1);
    wbRead(idLoAdr, 1'b0, word);
    wbRead(idHiAdr, 1'b0, word);
    wbRead(scratchAdr, 1'b0, word);
    wbRead(controlAdr, 1'b0, word);
    wbRead(countAdr, 1'b0, word);

    // Scratch and control, each read issued right after its write
    for (int i = 0; i < 8; i++)
    begin
      wbWrite(scratchAdr, randomWord(), 1'b1);
      wbRead(scratchAdr, 1'b0, word);
      wbWrite(controlAdr, randomWord(), 1'b1);
      wbRead(controlAdr, 1'b0, word);
      idle($urandom_range(0, 2));
    end

    // Writes to read-only and unmapped feature words still count
    wbWrite(featureAdr, randomWord(), 1'b0);
    wbWrite(countAdr, randomWord(), 1'b0);
    wbWrite(`FEATURE_BASE + 'h100, randomWord(), 1'b0);
    wbRead(featureAdr, 1'b0, word);
    wbRead(countAdr, 1'b0, word);

    // Unknown offsets read zero; beyond both regions reads all ones
    wbRead(nextAfuAdr, 1'b0, word);
    wbRead('h28, 1'b0, word);
    wbRead('h1ff8, 1'b0, word);
    wbRead(`FEATURE_BASE + 'h18, 1'b0, word);
    wbRead('h3ff8, 1'b0, word);
    wbWrite('h4000, randomWord(), 1'b0);
    wbWrite('h3fff8, randomWord(), 1'b0);
    wbRead('h4000, 1'b0, word);
    wbRead('h3fff8, 1'b0, word);
    wbRead(scratchAdr, 1'b0, word);
    wbRead(controlAdr, 1'b0, word);
    wbRead(countAdr, 1'b0, word);

    // Mixed traffic with idle gaps or with wbStb held into the next access
    for (int i = 0; i < 40; i++)
    begin
      adr  = randomAddr();
      hold = ($urandom_range(0, 2) == 0);
      if ($urandom_range(0, 1) == 1)
        wbWrite(adr, randomWord(), hold);
      else
        wbRead(adr, hold, word);
      if (!hold)
        idle($urandom_range(0, 3));
    end
    wbRead(countAdr, 1'b0, word);

    waited = 0;
    while (pendAdr.size() != 0)
    begin
      @(negedge pClk);
      waited++;
      if (waited > drainTimeout)
        failRun("Timeout while waiting for the last acknowledges");
    end
    // A few quiet cycles expose any stray acknowledge
    idle(4);

    if (uut.handshakeChecks.failCount != 0)
    begin
      failRun("A Wishbone handshake assertion failed");
    end
    else
    begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

/* src.f */
+incdir+logic
logic/mmioPkg.sv
logic/dfhPkg.sv
logic/mmioIf.sv
logic/afuCsr.sv
logic/featureCsr.sv
logic/mmioDecode.sv
logic/ccipStdAfu.sv
tests/ccipStdAfu_asserts.sv
tests/ccipStdAfuTb.sv

/* Bender.yml */
package:
  name: ccip_std_afu

export_include_dirs:
  - logic

sources:
  # Synthesizable AFU shell, packages first
  - target: any(rtl, test)
    files:
      - logic/mmioPkg.sv
      - logic/dfhPkg.sv
      - logic/mmioIf.sv
      - logic/afuCsr.sv
      - logic/featureCsr.sv
      - logic/mmioDecode.sv
      - logic/ccipStdAfu.sv
  # Bound handshake checker and testbench
  - target: test
    files:
      - tests/ccipStdAfu_asserts.sv
      - tests/ccipStdAfuTb.sv
